// File: Makefile
# Verilator build and run of the histogram peak finder testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, log to $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --assert -Wno-fatal -f tb.f --top-module sifhTb -o sifhTb
	./obj_dir/sifhTb | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "result: FAIL"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: hw/histAccum.sv
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module histAccum (
    input  logic               clk,
    input  logic               res,
    input  logic               en,
    input  sifhPkg::accumModeT mode,
    input  sifhPkg::stampT     thLow,
    input  sifhPkg::stampBeatT beat,
    input  logic               beatFire,
    output sifhPkg::binT       rdAddr,
    input  sifhPkg::countT     rdData,
    output sifhPkg::ramWrT     wr,
    output logic               idle
);

    sifhPkg::stampT shifted;     // stamp reduced to its coarse bin
    sifhPkg::stampT winShift;    // coarse bin of the window base
    sifhPkg::binT   inBin;
    logic           keep;

    logic           s1Valid;
    sifhPkg::binT   s1Bin;
    logic           fwdHit;
    sifhPkg::countT fwdCnt;
    sifhPkg::countT baseCnt;
    sifhPkg::countT newCnt;

    // stage 0: bin mapping and window test
    assign shifted  = beat.stamp >> `BIN_SHIFT;
    assign winShift = thLow >> `BIN_SHIFT;

    always_comb begin
        if (mode == sifhPkg::ACC_FINE) begin
            inBin = beat.stamp[`BIN_W-1:0];   // full resolution inside window
            keep  = (shifted == winShift);
        end else begin
            inBin = shifted[`BIN_W-1:0];
            keep  = 1'b1;
        end
    end

    assign rdAddr = inBin;   // RAM data arrives with the item in stage 1

    // the stage-1 write lands too late for a read issued in the same cycle,
    // so a matching bin takes the new count straight from stage 1
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            fwdHit  <= 1'b0;
        end else begin
            s1Valid <= en && beatFire && keep;
            fwdHit  <= s1Valid && (s1Bin == inBin);
        end
    end

    always_ff @(posedge clk) begin
        s1Bin  <= inBin;
        fwdCnt <= newCnt;
    end

    // stage 1: increment with saturation, then write back
    assign baseCnt = fwdHit ? fwdCnt : rdData;
    assign newCnt  = (&baseCnt) ? baseCnt : baseCnt + 1'b1;   // hold at max

    assign wr = sifhPkg::ramWrT'{en: s1Valid, addr: s1Bin, data: newCnt};

    assign idle = !s1Valid;   // nothing left to write

    // the control keeps en high until the pipe has drained
    assert property (@(posedge clk) disable iff (!res) wr.en |-> en)
        else $error("histAccum: RAM write while accumulator disabled");

endmodule

// File: hw/histRam.sv
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module histRam (
    input  logic            clk,
    input  sifhPkg::ramWrT  wr,
    input  sifhPkg::binT    rdAddr,
    output sifhPkg::countT  rdData
);

    sifhPkg::countT mem [`BIN_NUM];   // one count per bin

    // write port, used by clear and by the accumulator
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, returns the old value on a same-cycle write
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: hw/peakSearch.sv
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module peakSearch (
    input  logic           clk,
    input  logic           res,
    input  logic           start,
    input  sifhPkg::countT rdData,
    output sifhPkg::peakT  peak,
    output logic           done
);

    logic         dataValid;   // rdData belongs to dataBin
    sifhPkg::binT dataBin;
    logic         lastBin;

    assign lastBin = (dataBin == sifhPkg::binT'(`BIN_NUM - 1));

    // start comes with address 0, so bin 0 shows up one cycle later
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dataValid <= 1'b0;
            dataBin   <= '0;
            done      <= 1'b0;
            peak      <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                dataValid <= 1'b1;
                dataBin   <= '0;
                peak      <= '0;
            end else if (dataValid) begin
                // strictly greater keeps the lowest bin on a tie
                if (rdData > peak.count) begin
                    peak.bin   <= dataBin;
                    peak.count <= rdData;
                end
                dataBin <= dataBin + 1'b1;
                if (lastBin) begin
                    dataValid <= 1'b0;
                    done      <= 1'b1;   // peak now holds the final compare
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!res) start |-> !dataValid)
        else $error("peakSearch: start during an active scan");

endmodule

// File: hw/sifhCtrl.sv
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module sifhCtrl (
    input  logic               clk,
    input  logic               res,
    input  logic               start,
    input  sifhPkg::stampBeatT stampBeat,
    input  logic               stampValid,
    output logic               stampReady,
    output logic               accEn,
    output sifhPkg::accumModeT accMode,
    input  sifhPkg::binT       accRdAddr,
    input  sifhPkg::ramWrT     accWr,
    input  logic               accIdle,
    output sifhPkg::ramWrT     ramWr,
    output sifhPkg::binT       ramRdAddr,
    output logic               searchStart,
    input  sifhPkg::peakT      peak,
    input  logic               searchDone,
    output logic               busy,
    output logic               done,
    output sifhPkg::resultT    result
);

    sifhPkg::ctrlStateT state;
    sifhPkg::ctrlStateT nextState;
    sifhPkg::binT       addrCnt;    // clear and scan address
    logic               lastSeen;   // last beat of the frame has transferred
    logic               inClear;
    logic               inBuild;
    logic               inSearch;
    logic               lastBin;
    sifhPkg::stampT     winLow;

    assign inClear  = (state == sifhPkg::S_CLEAR1) || (state == sifhPkg::S_CLEAR2);
    assign inBuild  = (state == sifhPkg::S_BUILD1) || (state == sifhPkg::S_BUILD2);
    assign inSearch = (state == sifhPkg::S_SEARCH1) || (state == sifhPkg::S_SEARCH2);
    assign lastBin  = (addrCnt == sifhPkg::binT'(`BIN_NUM - 1));
    assign winLow   = sifhPkg::stampT'(result.coarsePeak) << `BIN_SHIFT;

    always_comb begin
        nextState = state;
        case (state)
            sifhPkg::S_IDLE:    if (start) nextState = sifhPkg::S_CLEAR1;
            sifhPkg::S_CLEAR1:  if (lastBin) nextState = sifhPkg::S_BUILD1;
            sifhPkg::S_BUILD1:  if (lastSeen && accIdle) nextState = sifhPkg::S_SEARCH1;
            sifhPkg::S_SEARCH1: if (searchDone) nextState = sifhPkg::S_WINDOW;
            sifhPkg::S_WINDOW:  nextState = sifhPkg::S_CLEAR2;
            sifhPkg::S_CLEAR2:  if (lastBin) nextState = sifhPkg::S_BUILD2;
            sifhPkg::S_BUILD2:  if (lastSeen && accIdle) nextState = sifhPkg::S_SEARCH2;
            sifhPkg::S_SEARCH2: if (searchDone) nextState = sifhPkg::S_DONE;
            sifhPkg::S_DONE:    nextState = sifhPkg::S_IDLE;
            default:            nextState = sifhPkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= sifhPkg::S_IDLE;
            addrCnt     <= '0;
            lastSeen    <= 1'b0;
            searchStart <= 1'b0;
        end else begin
            state <= nextState;
            if (nextState != state) begin
                addrCnt <= '0;   // every clear and scan starts at bin 0
            end else if (inClear || inSearch) begin
                addrCnt <= addrCnt + 1'b1;
            end
            if (!inBuild) begin
                lastSeen <= 1'b0;
            end else if (stampValid && stampReady && stampBeat.last) begin
                lastSeen <= 1'b1;
            end
            searchStart <= (nextState != state) &&
                           ((nextState == sifhPkg::S_SEARCH1) ||
                            (nextState == sifhPkg::S_SEARCH2));
        end
    end

    // ready drops after the last beat so the pipe drains
    assign stampReady = inBuild && !lastSeen;
    assign accEn      = inBuild;
    assign accMode    = (state == sifhPkg::S_BUILD2) ? sifhPkg::ACC_FINE : sifhPkg::ACC_COARSE;

    // RAM port mux
    always_comb begin
        if (inClear) begin
            ramWr = '{en: 1'b1, addr: addrCnt, data: '0};
        end else if (inBuild) begin
            ramWr = accWr;
        end else begin
            ramWr = '0;
        end
        ramRdAddr = inBuild ? accRdAddr : addrCnt;
    end

    always_ff @(posedge clk) begin
        if ((state == sifhPkg::S_SEARCH1) && searchDone) begin
            result.coarsePeak <= peak.bin;
        end
        if (state == sifhPkg::S_WINDOW) begin
            result.thLow  <= winLow;
            result.thHigh <= winLow + sifhPkg::stampT'(`BIN_NUM - 1);
        end
        if ((state == sifhPkg::S_SEARCH2) && searchDone) begin
            result.finePeak  <= result.thLow + sifhPkg::stampT'(peak.bin);
            result.peakCount <= peak.count;
        end
    end

    assign busy = (state != sifhPkg::S_IDLE);
    assign done = (state == sifhPkg::S_DONE);

    // a peak reported outside a search would never reach the result
    assert property (@(posedge clk) disable iff (!res) searchDone |-> inSearch)
        else $error("sifhCtrl: searchDone outside a search state");

endmodule

// File: hw/sifhPkg.sv
`include "sifh_cfg.svh"

package sifhPkg;

    typedef logic [`STAMP_W-1:0] stampT;   // raw timestamp
    typedef logic [`BIN_W-1:0]   binT;     // histogram bin address
    typedef logic [`CNT_W-1:0]   countT;   // bin count, saturating

    typedef struct packed {
        stampT stamp;
        logic  last;    // final stamp of a frame
    } stampBeatT;

    typedef struct packed {
        logic  en;
        binT   addr;
        countT data;
    } ramWrT;

    typedef enum logic {
        ACC_COARSE,     // bin = top bits of the stamp
        ACC_FINE        // bin = low bits, window filtered
    } accumModeT;

    typedef struct packed {
        binT   coarsePeak;
        stampT thLow;
        stampT thHigh;
        stampT finePeak;
        countT peakCount;
    } resultT;

    typedef enum logic [3:0] {
        S_CLEAR1,
        S_BUILD1,
        S_SEARCH1,
        S_WINDOW,
        S_CLEAR2,
        S_BUILD2,
        S_SEARCH2,
        S_DONE,
        S_IDLE
    } ctrlStateT;

    typedef struct packed {
        binT   bin;
        countT count;
    } peakT;

endpackage

// File: hw/sifhTop.sv
`timescale 1ns/1ps

module sifhTop (
    input  logic               clk,
    input  logic               res,
    input  sifhPkg::stampBeatT stampBeat,
    input  logic               stampValid,
    output logic               stampReady,
    input  logic               start,
    output logic               busy,
    output logic               done,
    output sifhPkg::resultT    result
);

    logic               accEn;
    sifhPkg::accumModeT accMode;
    sifhPkg::binT       accRdAddr;
    sifhPkg::ramWrT     accWr;
    logic               accIdle;
    sifhPkg::ramWrT     ramWr;
    sifhPkg::binT       ramRdAddr;
    sifhPkg::countT     ramRdData;
    logic               searchStart;
    sifhPkg::peakT      peak;
    logic               searchDone;
    logic               beatFire;

    assign beatFire = stampValid & stampReady;   // stream transfer

    histRam u_histRam (
        .clk    (clk),
        .wr     (ramWr),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

    histAccum u_histAccum (
        .clk      (clk),
        .res      (res),
        .en       (accEn),
        .mode     (accMode),
        .thLow    (result.thLow),
        .beat     (stampBeat),
        .beatFire (beatFire),
        .rdAddr   (accRdAddr),
        .rdData   (ramRdData),
        .wr       (accWr),
        .idle     (accIdle)
    );

    peakSearch u_peakSearch (
        .clk    (clk),
        .res    (res),
        .start  (searchStart),
        .rdData (ramRdData),
        .peak   (peak),
        .done   (searchDone)
    );

    sifhCtrl u_sifhCtrl (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .stampBeat   (stampBeat),
        .stampValid  (stampValid),
        .stampReady  (stampReady),
        .accEn       (accEn),
        .accMode     (accMode),
        .accRdAddr   (accRdAddr),
        .accWr       (accWr),
        .accIdle     (accIdle),
        .ramWr       (ramWr),
        .ramRdAddr   (ramRdAddr),
        .searchStart (searchStart),
        .peak        (peak),
        .searchDone  (searchDone),
        .busy        (busy),
        .done        (done),
        .result      (result)
    );

endmodule

// File: hw/sifh_cfg.svh
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// timestamp from the TDC
`define STAMP_W 12

// one histogram covers BIN_NUM bins
`define BIN_NUM 64

// bin address width, log2 of BIN_NUM
`define BIN_W 6

// stamp >> BIN_SHIFT gives the coarse bin
`define BIN_SHIFT 6

// counts saturate at the all-ones value
`define CNT_W 8

`endif

// File: tb.f
+incdir+hw
hw/sifhPkg.sv
hw/histRam.sv
hw/histAccum.sv
hw/peakSearch.sv
hw/sifhCtrl.sv
hw/sifhTop.sv
tests/sifhTb.sv

// File: tests/sifhTb.sv
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module sifhTb;

    localparam int TIMEOUT = 6 * (4 * 70 + 2 * 600);   // cycles for all runs
    localparam int CNT_MAX = (1 << `CNT_W) - 1;

    logic               clk;
    logic               res;
    sifhPkg::stampBeatT stampBeat;
    logic               stampValid;
    logic               stampReady;
    logic               start;
    logic               busy;
    logic               done;
    sifhPkg::resultT    result;

    logic [31:0]        lfsr;
    int                 cycles = 0;
    int                 errCnt;      // errors of the running test
    int                 passCnt;
    int                 failCnt;
    string              testName;
    logic               useGaps;     // random holes in stampValid
    sifhPkg::stampT     frame1[$];   // pass 1 stamps
    sifhPkg::stampT     frame2[$];   // pass 2 stamps
    sifhPkg::resultT    lastRes;

    sifhTop u_sifhTop (
        .clk        (clk),
        .res        (res),
        .stampBeat  (stampBeat),
        .stampValid (stampValid),
        .stampReady (stampReady),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("ERROR: simulation timed out after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // expected result from the two-pass binning rules
    function automatic sifhPkg::resultT predict();
        int              hist [`BIN_NUM];
        int              b;
        int              best;
        sifhPkg::resultT r;
        foreach (hist[i]) hist[i] = 0;
        foreach (frame1[i]) begin
            b = int'(frame1[i] >> `BIN_SHIFT);   // coarse bin
            if (hist[b] < CNT_MAX) hist[b]++;
        end
        best = 0;
        for (int i = 1; i < `BIN_NUM; i++) begin
            if (hist[i] > hist[best]) best = i;   // lowest index on a tie
        end
        r.coarsePeak = sifhPkg::binT'(best);
        r.thLow      = sifhPkg::stampT'(best) << `BIN_SHIFT;
        r.thHigh     = r.thLow + sifhPkg::stampT'(63);
        foreach (hist[i]) hist[i] = 0;
        foreach (frame2[i]) begin
            if (int'(frame2[i] >> `BIN_SHIFT) == best) begin   // inside the window
                b = int'(frame2[i][`BIN_W-1:0]);
                if (hist[b] < CNT_MAX) hist[b]++;
            end
        end
        best = 0;
        for (int i = 1; i < `BIN_NUM; i++) begin
            if (hist[i] > hist[best]) best = i;
        end
        r.finePeak  = r.thLow + sifhPkg::stampT'(best);
        r.peakCount = sifhPkg::countT'(hist[best]);
        return r;
    endfunction

    task automatic checkVal(input string field, input int exp, input int act);
        assert (act == exp) else begin
            $display("FAILED %s %s: expected %0d actual %0d", testName, field, exp, act);
            errCnt++;
        end
    endtask

    task automatic pushStamp(input bit second, input sifhPkg::stampT s);
        if (second) begin
            frame2.push_back(s);
        end else begin
            frame1.push_back(s);
        end
    endtask

    // stamps of one coarse bin, low bits spread around a base
    task automatic pushCluster(input bit second, input int count, input int bin,
                               input int low, input int spread);
        int lowBits;
        for (int i = 0; i < count; i++) begin
            lowBits = (low + int'(randBits(spread))) % `BIN_NUM;
            pushStamp(second, sifhPkg::stampT'((bin << `BIN_SHIFT) + lowBits));
        end
    endtask

    // random stamps, optionally kept out of one coarse bin
    task automatic pushNoise(input bit second, input int count, input int avoid);
        sifhPkg::stampT s;
        for (int i = 0; i < count; i++) begin
            s = sifhPkg::stampT'(randBits(`STAMP_W));
            if (int'(s >> `BIN_SHIFT) == avoid) begin
                s[`STAMP_W-1] = ~s[`STAMP_W-1];
            end
            pushStamp(second, s);
        end
    endtask

    task automatic sendFrame(input bit second);
        int n;
        n = second ? frame2.size() : frame1.size();
        for (int i = 0; i < n; i++) begin
            if (useGaps && randBits(2) == 0) begin
                stampValid = 1'b0;
                repeat (1 + randBits(2)) @(negedge clk);
            end
            stampBeat.stamp = second ? frame2[i] : frame1[i];
            stampBeat.last  = (i == n - 1);
            stampValid      = 1'b1;
            while (!stampReady) @(negedge clk);   // ready only moves on posedge
            @(negedge clk);
        end
        stampValid = 1'b0;
    endtask

    // one start, two frames, then wait for done and compare
    task automatic runCase();
        sifhPkg::resultT exp;
        exp   = predict();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (busy) else begin
            $display("%s: busy did not rise after start", testName);
            errCnt++;
        end
        sendFrame(1'b0);
        sendFrame(1'b1);
        while (!done) begin
            assert (busy) else begin
                $display("%s: busy dropped before done", testName);
                errCnt++;
            end
            @(negedge clk);
        end
        lastRes = result;
        checkVal("coarsePeak", int'(exp.coarsePeak), int'(result.coarsePeak));
        checkVal("thLow", int'(exp.thLow), int'(result.thLow));
        checkVal("thHigh", int'(exp.thHigh), int'(result.thHigh));
        checkVal("finePeak", int'(exp.finePeak), int'(result.finePeak));
        checkVal("peakCount", int'(exp.peakCount), int'(result.peakCount));
        @(negedge clk);
        assert (!done && !busy) else begin
            $display("%s: done longer than one cycle or busy still high", testName);
            errCnt++;
        end
    endtask

    task automatic beginTest(input string name);
        testName = name;
        errCnt   = 0;
        frame1.delete();
        frame2.delete();
    endtask

    task automatic endTest();
        if (errCnt == 0) begin
            passCnt++;
            $display("PASS %s", testName);
        end else begin
            failCnt++;
            $display("FAIL %s with %0d errors", testName, errCnt);
        end
    endtask

    task automatic resetCheck();
        beginTest("resetCheck");
        assert (!stampReady && !busy && !done) else begin
            $display("stampReady, busy or done not low after reset");
            errCnt++;
        end
        pushCluster(1'b0, 8, 5, 10, 2);
        pushCluster(1'b1, 8, 5, 10, 2);
        runCase();
        endTest();
    endtask

    task automatic clusterNoise();
        beginTest("clusterNoise");
        pushNoise(1'b0, 120, -1);
        pushCluster(1'b0, 80, 37, 0, 6);
        pushNoise(1'b1, 60, -1);
        pushCluster(1'b1, 100, 37, 20, 3);
        runCase();
        endTest();
    endtask

    task automatic windowFilter();
        sifhPkg::resultT first;
        beginTest("windowFilter");
        pushCluster(1'b0, 60, 12, 0, 6);
        pushNoise(1'b1, 40, 12);
        pushCluster(1'b1, 50, 12, 33, 2);
        runCase();
        first = lastRes;
        pushNoise(1'b1, 200, 12);   // only more out-of-window stamps
        runCase();
        checkVal("finePeak vs first run", int'(first.finePeak), int'(lastRes.finePeak));
        checkVal("peakCount vs first run", int'(first.peakCount), int'(lastRes.peakCount));
        endTest();
    endtask

    task automatic ties();
        beginTest("ties");
        pushCluster(1'b0, 10, 40, 3, 0);
        pushCluster(1'b0, 10, 9, 7, 0);
        pushCluster(1'b0, 5, 20, 0, 0);
        pushCluster(1'b1, 6, 9, 50, 0);
        pushCluster(1'b1, 6, 9, 17, 0);
        runCase();
        checkVal("coarse tie", 9, int'(lastRes.coarsePeak));
        checkVal("fine tie", 9 * 64 + 17, int'(lastRes.finePeak));
        endTest();
    endtask

    task automatic saturation();
        beginTest("saturation");
        pushCluster(1'b0, 300, 38, 37, 0);   // back to back on one bin
        pushCluster(1'b1, 300, 38, 37, 0);
        runCase();
        checkVal("saturated count", CNT_MAX, int'(lastRes.peakCount));
        endTest();
    endtask

    task automatic gapsBackToBack();
        beginTest("gapsBackToBack");
        useGaps = 1'b1;
        pushNoise(1'b0, 100, -1);
        pushCluster(1'b0, 150, 50, 0, 6);
        pushNoise(1'b1, 80, -1);
        pushCluster(1'b1, 120, 50, 40, 3);
        runCase();
        frame1.delete();
        frame2.delete();
        pushNoise(1'b0, 100, -1);   // weaker peak, stale counts would win
        pushCluster(1'b0, 60, 3, 0, 6);
        pushNoise(1'b1, 40, -1);
        pushCluster(1'b1, 50, 3, 8, 2);
        runCase();
        useGaps = 1'b0;
        endTest();
    endtask

    initial begin
        clk        = 1'b0;
        res        = 1'b0;
        start      = 1'b0;
        stampValid = 1'b0;
        stampBeat  = '0;
        lfsr       = 32'hce18_885c;
        passCnt    = 0;
        failCnt    = 0;
        useGaps    = 1'b0;
        repeat (8) @(negedge clk);
        res = 1'b1;
        @(negedge clk);
        resetCheck();
        clusterNoise();
        windowFilter();
        ties();
        saturation();
        gapsBackToBack();
        $display("tests passed: %0d, tests failed: %0d", passCnt, failCnt);
        if (failCnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
